// File: hdl/eth_udp_pkg.sv
package eth_udp_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    localparam int HDR_BYTES = 42;

    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;
    // Version 4 with a header of five 32-bit words
    localparam logic [7:0]  IP_VER_IHL    = 8'h45;

    typedef struct packed {
        mac_addr_t   dest_mac;
        ip_addr_t    dest_ip;
        logic [15:0] dest_port;
        logic [15:0] payload_len;
    } udp_req_t;

    // First byte on the wire sits in the top bits
    typedef struct packed {
        // Ethernet
        mac_addr_t   eth_dst;
        mac_addr_t   eth_src;
        logic [15:0] eth_type;
        // IPv4
        logic [7:0]  ip_ver_ihl;
        logic [7:0]  ip_dscp_ecn;
        logic [15:0] ip_total_len;
        logic [15:0] ip_id;
        logic [15:0] ip_flags_frag;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_proto;
        logic [15:0] ip_csum;
        ip_addr_t    ip_src;
        ip_addr_t    ip_dst;
        // UDP
        logic [15:0] udp_src_port;
        logic [15:0] udp_dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_csum;
    } frame_hdr_t;

    // Field view for building and byte view for sending
    typedef union packed {
        frame_hdr_t                      f;
        logic [HDR_BYTES-1:0][7:0]       bytes;
    } frame_hdr_u;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

endpackage

// File: hdl/udp_hdr_builder.sv
`timescale 1ns/1ps

module udp_hdr_builder #(
    parameter eth_udp_pkg::mac_addr_t LOCAL_MAC = 48'h02_00_00_00_00_01,
    parameter eth_udp_pkg::ip_addr_t  LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter logic [15:0]            SRC_PORT  = 16'd1234,
    parameter logic [7:0]             TTL       = 8'd64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  eth_udp_pkg::udp_req_t   req,
    output eth_udp_pkg::frame_hdr_u hdr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr <= '0;
        end else if (start) begin
            hdr.f.eth_dst       <= req.dest_mac;
            hdr.f.eth_src       <= LOCAL_MAC;
            hdr.f.eth_type      <= eth_udp_pkg::ETH_TYPE_IPV4;

            hdr.f.ip_ver_ihl    <= eth_udp_pkg::IP_VER_IHL;
            hdr.f.ip_dscp_ecn   <= 8'h00;
            // IPv4 header plus UDP header plus payload
            hdr.f.ip_total_len  <= req.payload_len + 16'd28;
            hdr.f.ip_id         <= 16'h0000;
            hdr.f.ip_flags_frag <= 16'h0000;
            hdr.f.ip_ttl        <= TTL;
            hdr.f.ip_proto      <= eth_udp_pkg::IP_PROTO_UDP;
            // Filled in by the serializer
            hdr.f.ip_csum       <= 16'h0000;
            hdr.f.ip_src        <= LOCAL_IP;
            hdr.f.ip_dst        <= req.dest_ip;

            hdr.f.udp_src_port  <= SRC_PORT;
            hdr.f.udp_dst_port  <= req.dest_port;
            hdr.f.udp_len       <= req.payload_len + 16'd8;
            hdr.f.udp_csum      <= 16'h0000;
        end
    end

endmodule

// File: hdl/ip_csum_unit.sv
`timescale 1ns/1ps

module ip_csum_unit #(
    parameter eth_udp_pkg::ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter logic [7:0]            TTL      = 8'd64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  eth_udp_pkg::udp_req_t req,
    output logic [15:0]           csum,
    output logic                  csum_valid
);

    // Header half-words that never change between frames
    localparam logic [19:0] CONST_SUM =
        20'({eth_udp_pkg::IP_VER_IHL, 8'h00}) +
        20'({TTL, eth_udp_pkg::IP_PROTO_UDP}) +
        20'(LOCAL_IP[31:16]) +
        20'(LOCAL_IP[15:0]);

    logic [15:0] total_len;
    logic [19:0] sum_req;
    logic [19:0] sum_all;
    logic [16:0] fold_once;
    logic [16:0] fold_twice;
    logic        v1;
    logic        v2;

    assign total_len = req.payload_len + 16'd28;

    // Second fold catches the carry from the first
    assign fold_once  = 17'(sum_all[15:0]) + 17'(sum_all[19:16]);
    assign fold_twice = 17'(fold_once[15:0]) + 17'(fold_once[16]);

    always_ff @(posedge clk) begin
        if (rst) begin
            v1         <= 1'b0;
            v2         <= 1'b0;
            csum_valid <= 1'b0;
        end else begin
            v1         <= start;
            v2         <= v1;
            csum_valid <= v2;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sum_req <= 20'(req.dest_ip[31:16]) + 20'(req.dest_ip[15:0]) + 20'(total_len);
        end
        sum_all <= sum_req + CONST_SUM;
        csum    <= ~fold_twice[15:0];
    end

endmodule

// File: hdl/frame_serializer.sv
`timescale 1ns/1ps

module frame_serializer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    output logic                    start,
    input  eth_udp_pkg::frame_hdr_u hdr,
    input  logic [15:0]             csum,
    input  logic                    csum_valid,
    input  eth_udp_pkg::byte_beat_t pay,
    input  logic                    pay_valid,
    output logic                    pay_ready,
    output eth_udp_pkg::byte_beat_t out,
    output logic                    out_valid,
    input  logic                    out_ready
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1;
    localparam logic [1:0] ST_HDR  = 2'd2;
    localparam logic [1:0] ST_PAY  = 2'd3;

    localparam logic [5:0] FIRST_IDX = 6'(eth_udp_pkg::HDR_BYTES - 1);

    logic [1:0]              state;
    logic [5:0]              byte_idx;
    eth_udp_pkg::frame_hdr_u hdr_in;
    eth_udp_pkg::frame_hdr_u hdr_reg;

    assign req_ready = (state == ST_IDLE);
    assign start     = req_valid && req_ready;

    always_comb begin
        hdr_in           = hdr;
        hdr_in.f.ip_csum = csum;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            byte_idx <= FIRST_IDX;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (csum_valid) begin
                        state    <= ST_HDR;
                        byte_idx <= FIRST_IDX;
                    end
                end
                ST_HDR: begin
                    if (out_ready) begin
                        if (byte_idx == 6'd0) begin
                            state <= ST_PAY;
                        end else begin
                            byte_idx <= byte_idx - 6'd1;
                        end
                    end
                end
                default: begin
                    if (pay_valid && out_ready && pay.last) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT && csum_valid) begin
            hdr_reg <= hdr_in;
        end
    end

    // Header from the byte view, then payload straight through
    always_comb begin
        out       = '0;
        out_valid = 1'b0;
        pay_ready = 1'b0;
        if (state == ST_HDR) begin
            out.data  = hdr_reg.bytes[byte_idx];
            out_valid = 1'b1;
        end else if (state == ST_PAY) begin
            out       = pay;
            out_valid = pay_valid;
            pay_ready = out_ready;
        end
    end

endmodule

// File: hdl/udp_tx_framer.sv
`timescale 1ns/1ps

module udp_tx_framer #(
    parameter eth_udp_pkg::mac_addr_t LOCAL_MAC = 48'h02_00_00_00_00_01,
    parameter eth_udp_pkg::ip_addr_t  LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter logic [15:0]            SRC_PORT  = 16'd1234,
    parameter logic [7:0]             TTL       = 8'd64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_udp_pkg::udp_req_t   req,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  eth_udp_pkg::byte_beat_t pay,
    input  logic                    pay_valid,
    output logic                    pay_ready,
    output eth_udp_pkg::byte_beat_t out,
    output logic                    out_valid,
    input  logic                    out_ready
);

    logic                    start;
    eth_udp_pkg::frame_hdr_u hdr;
    logic [15:0]             csum;
    logic                    csum_valid;

    udp_hdr_builder #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .SRC_PORT  (SRC_PORT),
        .TTL       (TTL)
    ) u_builder (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .req   (req),
        .hdr   (hdr)
    );

    ip_csum_unit #(
        .LOCAL_IP (LOCAL_IP),
        .TTL      (TTL)
    ) u_csum (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .req        (req),
        .csum       (csum),
        .csum_valid (csum_valid)
    );

    frame_serializer u_serializer (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .start      (start),
        .hdr        (hdr),
        .csum       (csum),
        .csum_valid (csum_valid),
        .pay        (pay),
        .pay_valid  (pay_valid),
        .pay_ready  (pay_ready),
        .out        (out),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

// File: tb/udp_frame_model.svh
`ifndef UDP_FRAME_MODEL_SVH
`define UDP_FRAME_MODEL_SVH

// Ones' complement sum of the ten IPv4 header half-words
function automatic logic [15:0] ones_sum(input logic [159:0] ip_hdr);
    logic [31:0] acc;
    acc = 32'd0;
    for (int i = 0; i < 10; i++) begin
        acc = acc + {16'd0, ip_hdr[i*16 +: 16]};
    end
    while (acc[31:16] != 16'd0) begin
        acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
    end
    return acc[15:0];
endfunction

// Full wire image of one frame as header bytes and then payload
function automatic byte_q_t expected_frame(input eth_udp_pkg::udp_req_t r,
                                           input byte_q_t payload);
    byte_q_t      q;
    logic [15:0]  total_len;
    logic [15:0]  udp_len;
    logic [159:0] ip_hdr;
    logic [335:0] hdr_bits;
    q = {};
    total_len = r.payload_len + 16'd28;
    udp_len = r.payload_len + 16'd8;
    ip_hdr = {8'h45, 8'h00, total_len, 16'h0000, 16'h0000, TTL, 8'd17, 16'h0000,
              LOCAL_IP, r.dest_ip};
    // Checksum field sits at bits 79:64 of the IP header
    ip_hdr[79:64] = ~ones_sum(ip_hdr);
    hdr_bits = {r.dest_mac, LOCAL_MAC, 16'h0800, ip_hdr,
                SRC_PORT, r.dest_port, udp_len, 16'h0000};
    for (int i = 41; i >= 0; i--) begin
        q.push_back(hdr_bits[i*8 +: 8]);
    end
    foreach (payload[i]) begin
        q.push_back(payload[i]);
    end
    return q;
endfunction

`endif

// File: tb/udp_tx_framer_tb.sv
`timescale 1ns/1ps

module udp_tx_framer_tb;

    localparam eth_udp_pkg::mac_addr_t LOCAL_MAC = 48'h02_1a_2b_3c_4d_5e;
    localparam eth_udp_pkg::ip_addr_t  LOCAL_IP  = {8'd10, 8'd0, 8'd0, 8'd7};
    localparam logic [15:0]            SRC_PORT  = 16'd5000;
    localparam logic [7:0]             TTL       = 8'd32;
    localparam int N_REQ = 24;
    localparam int MAX_LEN = 64;
    localparam int TIMEOUT_CYCLES = 4 * (N_REQ * 50 + N_REQ * MAX_LEN);

    typedef logic [7:0] byte_q_t [$];

    logic clk = 1'b0;
    logic rst;
    eth_udp_pkg::udp_req_t   req;
    logic                    req_valid;
    logic                    req_ready;
    eth_udp_pkg::byte_beat_t pay;
    logic                    pay_valid;
    logic                    pay_ready;
    eth_udp_pkg::byte_beat_t out;
    logic                    out_valid;
    logic                    out_ready = 1'b0;

    integer seed = 17106;
    int error_count = 0;
    int frames_seen = 0;
    int cycles = 0;
    bit back_pressure = 1'b0;
    bit pay_gaps = 1'b0;
    logic in_flight;
    logic [31:0] ready_rnd;
    logic [7:0] exp_byte;
    logic exp_end;
    logic [159:0] ip_bits;
    eth_udp_pkg::udp_req_t req_list[$];
    int len_list[$];
    byte_q_t pay_list;
    byte_q_t exp_bytes;
    bit exp_last[$];
    byte_q_t got_frame;

    `include "udp_frame_model.svh"

    udp_tx_framer #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .SRC_PORT  (SRC_PORT),
        .TTL       (TTL)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .pay       (pay),
        .pay_valid (pay_valid),
        .pay_ready (pay_ready),
        .out       (out),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic drive_requests();
        foreach (req_list[i]) begin
            req <= req_list[i];
            req_valid <= 1'b1;
            @(posedge clk);
            while (!req_ready) @(posedge clk);
        end
        req_valid <= 1'b0;
    endtask

    task automatic drive_payload();
        logic [31:0] rnd;
        int k;
        k = 0;
        foreach (len_list[f]) begin
            for (int b = 0; b < len_list[f]; b++) begin
                rnd = $random(seed);
                if (pay_gaps && rnd[1:0] == 2'b00) begin
                    pay_valid <= 1'b0;
                    @(posedge clk);
                end
                pay.data <= pay_list[k];
                pay.last <= (b == len_list[f] - 1);
                pay_valid <= 1'b1;
                k++;
                @(posedge clk);
                while (!pay_ready) @(posedge clk);
            end
        end
        pay_valid <= 1'b0;
    endtask

    task automatic run_frames(input int count, input int max_len, input bit bp, input bit gaps);
        eth_udp_pkg::udp_req_t r;
        byte_q_t payload;
        byte_q_t frame;
        logic [31:0] rnd;
        logic [31:0] rnd_hi;
        int len;
        int target;
        req_list = {};
        len_list = {};
        pay_list = {};
        for (int n = 0; n < count; n++) begin
            rnd = $random(seed);
            rnd_hi = $random(seed);
            r.dest_mac = {rnd_hi[15:0], rnd};
            r.dest_ip = $random(seed);
            rnd = $random(seed);
            r.dest_port = rnd[15:0];
            rnd = $random(seed);
            len = 1 + int'(rnd % 32'(max_len));
            r.payload_len = 16'(len);
            payload = {};
            for (int b = 0; b < len; b++) begin
                rnd = $random(seed);
                payload.push_back(rnd[7:0]);
                pay_list.push_back(rnd[7:0]);
            end
            frame = expected_frame(r, payload);
            foreach (frame[i]) begin
                exp_bytes.push_back(frame[i]);
                exp_last.push_back(i == frame.size() - 1);
            end
            req_list.push_back(r);
            len_list.push_back(len);
        end
        target = frames_seen + count;
        back_pressure = bp;
        pay_gaps = gaps;
        fork
            drive_requests();
            drive_payload();
        join
        wait (frames_seen == target);
        back_pressure = 1'b0;
        pay_gaps = 1'b0;
    endtask

    always @(posedge clk) begin
        if (back_pressure) begin
            ready_rnd = $random(seed);
            out_ready <= (ready_rnd[1:0] != 2'b00);
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Compare every transferred output byte with the model
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_bytes.size() == 0) begin
                report_error("output byte arrived while no frame was expected");
            end else begin
                exp_byte = exp_bytes.pop_front();
                exp_end = exp_last.pop_front();
                check_value("out.data", 32'(out.data), 32'(exp_byte));
                if (out.last && !exp_end) begin
                    report_error("last flag came before the end of the frame");
                end
                if (!out.last && exp_end) begin
                    report_error("last flag missing on the final byte of the frame");
                end
                got_frame.push_back(out.data);
                if (exp_end) begin
                    for (int i = 0; i < 20; i++) begin
                        ip_bits[159 - 8*i -: 8] = got_frame[14 + i];
                    end
                    // A valid IP header sums to all ones
                    check_value("ip header sum", 32'(ones_sum(ip_bits)), 32'h0000ffff);
                    got_frame = {};
                    frames_seen++;
                end
            end
        end
    end

    // Ready only between the end of one frame and the next acceptance
    always @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
        end else begin
            check_value("req_ready", 32'(req_ready), 32'(!in_flight));
            if (req_valid && req_ready) begin
                in_flight <= 1'b1;
            end else if (out_valid && out_ready && out.last) begin
                in_flight <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d frames checked, %0d errors",
                     cycles, frames_seen, error_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        req = '0;
        req_valid = 1'b0;
        pay = '0;
        pay_valid = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("req_ready", 32'(req_ready), 32'd1);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("pay_ready", 32'(pay_ready), 32'd0);

        // Single minimum frame, then random fields, back-pressure and gaps
        run_frames(1, 1, 1'b0, 1'b0);
        run_frames(6, MAX_LEN, 1'b0, 1'b0);
        run_frames(6, MAX_LEN, 1'b1, 1'b0);
        run_frames(6, MAX_LEN, 1'b0, 1'b1);
        run_frames(5, MAX_LEN, 1'b1, 1'b1);

        // Stray bytes after the last frame show up in the compare process
        repeat (5) @(posedge clk);
        $display("Frames checked: %0d, errors: %0d", frames_seen, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+tb
hdl/eth_udp_pkg.sv
hdl/udp_hdr_builder.sv
hdl/ip_csum_unit.sv
hdl/frame_serializer.sv
hdl/udp_tx_framer.sv
tb/udp_tx_framer_tb.sv

// File: Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing --top-module udp_tx_framer_tb -f project.f -o udp_tx_framer_sim
	@out=$$(./obj_dir/udp_tx_framer_sim); echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
